//--- Bender.yml
package:
  name: iram_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/iram_pkg.sv
      - rtl/uart_word_rx.sv
      - rtl/iram_mem.sv
      - rtl/iram_controller.sv
      - rtl/fetch_unit.sv
      - rtl/iram_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_iram_top.sv

//--- build.f
+incdir+rtl
rtl/iram_pkg.sv
rtl/uart_word_rx.sv
rtl/iram_mem.sv
rtl/iram_controller.sv
rtl/fetch_unit.sv
rtl/iram_top.sv
sim/tb_iram_top.sv

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "iram_cfg.svh"

module fetch_unit (
    input logic clk,
    input logic rst,
    input logic rd_grant,
    input iram_pkg::word_t rd_data,
    input logic restart,
    input logic instr_ready,
    output iram_pkg::rd_req_s rd_req,
    output iram_pkg::fetch_out_s instr_out
);

    localparam int QD = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (QD > 1) ? $clog2(QD) : 1;
    localparam int CNT_W = $clog2(QD + 1);

    iram_pkg::iram_addr_t next_pc;
    iram_pkg::iram_addr_t inflight_pc;
    iram_pkg::iram_addr_t q_pc [QD];
    iram_pkg::word_t q_instr [QD];
    logic inflight;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] q_count;
    logic [CNT_W:0] occupancy;
    logic pop;
    logic fire;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // queued entries plus the read still coming back
    assign occupancy = {1'b0, q_count} + {{CNT_W{1'b0}}, inflight};
    assign pop = instr_out.valid && instr_ready;
    // an entry leaving this cycle frees its slot for a new read
    assign rd_req.req = (occupancy < (CNT_W + 1)'(QD)) || pop;
    assign rd_req.addr = next_pc;
    assign fire = rd_req.req && rd_grant;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            next_pc <= '0;
            inflight <= 1'b0;
            q_count <= '0;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            // pc wraps at the top of memory
            if (fire) begin
                next_pc <= next_pc + 1'b1;
            end
            inflight <= fire;
            if (inflight) begin
                wr_ptr <= (wr_ptr == PTR_W'(QD - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QD - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop can meet in one cycle
            if (inflight && !pop) begin
                q_count <= q_count + 1'b1;
            end else if (!inflight && pop) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // result queue storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fire) begin
            inflight_pc <= next_pc;
        end
        // ram data is valid the cycle after the grant
        if (inflight) begin
            q_pc[wr_ptr] <= inflight_pc;
            q_instr[wr_ptr] <= rd_data;
        end
    end

    // head of queue, held until taken
    assign instr_out.valid = (q_count != '0);
    assign instr_out.pc = q_pc[rd_ptr];
    assign instr_out.instr = q_instr[rd_ptr];

endmodule

//--- rtl/iram_cfg.svh
`ifndef IRAM_CFG_SVH
`define IRAM_CFG_SVH

////////////////////////////////////////
// instruction memory geometry
////////////////////////////////////////

// word address width, 1k words
`define IRAM_ADDR_W 10
`define IRAM_DEPTH (1 << `IRAM_ADDR_W)

// serial link, clocks per bit
`define UART_CLKS_PER_BIT 8

// program load framing words
`define IRAM_PROG_START 32'hdeadbeef
`define IRAM_PROG_END 32'hbaddab99

// fetch result queue entries
`define FETCH_QUEUE_DEPTH 2

`endif

//--- rtl/iram_controller.sv
`timescale 1ns/1ps
`include "iram_cfg.svh"

module iram_controller (
    input logic clk,
    input logic rst,
    input iram_pkg::rx_word_s rx_word,
    input iram_pkg::rd_req_s rd_req,
    output logic rd_grant,
    output iram_pkg::word_t rd_data,
    output logic restart,
    output logic loading
);

    iram_pkg::ctrl_state_e state;
    iram_pkg::iram_addr_t wr_addr;
    iram_pkg::iram_addr_t rd_addr_q;
    iram_pkg::iram_addr_t mem_addr;
    iram_pkg::word_t wr_data;
    logic wr_pend;
    logic start_hit;
    logic end_hit;
    logic data_hit;
    logic rd_fire;

    ////////////////////////////////////////
    // marker decode
    ////////////////////////////////////////

    // start marker only counts outside a load
    assign start_hit = rx_word.valid && (state == iram_pkg::CTRL_RUN)
                       && (rx_word.data == `IRAM_PROG_START);
    assign end_hit = rx_word.valid && (state == iram_pkg::CTRL_LOAD)
                     && (rx_word.data == `IRAM_PROG_END);
    // program word, markers never reach the ram
    assign data_hit = rx_word.valid && (state == iram_pkg::CTRL_LOAD)
                      && (rx_word.data != `IRAM_PROG_START)
                      && (rx_word.data != `IRAM_PROG_END);

    ////////////////////////////////////////
    // load state machine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= iram_pkg::CTRL_RUN;
            wr_addr <= '0;
            wr_pend <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            wr_pend <= data_hit;
            // step after each committed write
            if (wr_pend) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (start_hit) begin
                state <= iram_pkg::CTRL_LOAD;
                wr_addr <= '0;
            end else if (end_hit) begin
                state <= iram_pkg::CTRL_RUN;
            end
            // remember last read address so an idle port keeps rd_data
            if (rd_fire) begin
                rd_addr_q <= rd_req.addr;
            end
        end
    end

    // one word held for the write cycle
    always_ff @(posedge clk) begin
        if (data_hit) begin
            wr_data <= rx_word.data;
        end
    end

    ////////////////////////////////////////
    // ram port arbitration
    ////////////////////////////////////////

    // reads only while running and the port is free
    assign rd_grant = (state == iram_pkg::CTRL_RUN) && !end_hit && !wr_pend;
    assign rd_fire = rd_req.req && rd_grant;

    always_comb begin
        if (wr_pend) begin
            mem_addr = wr_addr;
        end else if (rd_fire) begin
            mem_addr = rd_req.addr;
        end else begin
            mem_addr = rd_addr_q;
        end
    end

    iram_mem u_mem (
        .clk(clk),
        .we(wr_pend),
        .addr(mem_addr),
        .wdata(wr_data),
        .rdata(rd_data)
    );

    // fetch side restarts as the load closes
    assign restart = end_hit;
    assign loading = (state == iram_pkg::CTRL_LOAD);

endmodule

//--- rtl/iram_mem.sv
`timescale 1ns/1ps
`include "iram_cfg.svh"

module iram_mem (
    input logic clk,
    input logic we,
    input iram_pkg::iram_addr_t addr,
    input iram_pkg::word_t wdata,
    output iram_pkg::word_t rdata
);

    ////////////////////////////////////////
    // single port block ram
    ////////////////////////////////////////

    // contents are left as loaded, no clear
    iram_pkg::word_t mem [`IRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read every cycle, read before write on a collision
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- rtl/iram_pkg.sv
`include "iram_cfg.svh"

package iram_pkg;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [`IRAM_ADDR_W-1:0] iram_addr_t;
    typedef logic [7:0] byte_t;

    // controller mode, RUN serves fetches, LOAD takes program words
    typedef enum logic {
        CTRL_RUN,
        CTRL_LOAD
    } ctrl_state_e;

    ////////////////////////////////////////
    // bundles between blocks
    ////////////////////////////////////////

    // one received word, valid is a single cycle pulse
    typedef struct packed {
        logic valid;
        word_t data;
    } rx_word_s;

    // fetch side read request
    typedef struct packed {
        logic req;
        iram_addr_t addr;
    } rd_req_s;

    // delivered instruction and its word address
    typedef struct packed {
        logic valid;
        iram_addr_t pc;
        word_t instr;
    } fetch_out_s;

endpackage

//--- rtl/iram_top.sv
`timescale 1ns/1ps

module iram_top (
    input logic clk,
    input logic rst,
    input logic rxd,
    input logic instr_ready,
    output iram_pkg::fetch_out_s instr_out,
    output logic loading
);

    iram_pkg::rx_word_s rx_word;
    iram_pkg::rd_req_s rd_req;
    iram_pkg::word_t rd_data;
    logic rd_grant;
    logic restart;

    ////////////////////////////////////////
    // serial word receiver
    ////////////////////////////////////////

    uart_word_rx u_rx (
        .clk(clk),
        .rst(rst),
        .rxd(rxd),
        .rx_word(rx_word)
    );

    ////////////////////////////////////////
    // memory controller and ram
    ////////////////////////////////////////

    iram_controller u_ctrl (
        .clk(clk),
        .rst(rst),
        .rx_word(rx_word),
        .rd_req(rd_req),
        .rd_grant(rd_grant),
        .rd_data(rd_data),
        .restart(restart),
        .loading(loading)
    );

    // sequential fetch toward the core
    fetch_unit u_fetch (
        .clk(clk),
        .rst(rst),
        .rd_grant(rd_grant),
        .rd_data(rd_data),
        .restart(restart),
        .instr_ready(instr_ready),
        .rd_req(rd_req),
        .instr_out(instr_out)
    );

endmodule

//--- rtl/uart_word_rx.sv
`timescale 1ns/1ps
`include "iram_cfg.svh"

module uart_word_rx (
    input logic clk,
    input logic rst,
    input logic rxd,
    output iram_pkg::rx_word_s rx_word
);

    localparam int CLKS = `UART_CLKS_PER_BIT;
    localparam int TMR_W = $clog2(CLKS);
    localparam logic [TMR_W-1:0] LAST_TICK = TMR_W'(CLKS - 1);
    localparam logic [TMR_W-1:0] HALF_TICK = TMR_W'(CLKS / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e state;
    logic rxd_meta;
    logic rxd_sync;
    logic [TMR_W-1:0] timer;
    logic [2:0] bit_idx;
    logic [1:0] byte_cnt;
    logic word_valid;
    logic bit_tick;
    logic sample_data;
    logic stop_ok;
    iram_pkg::byte_t shift_reg;
    iram_pkg::word_t word_buf;

    // full bit period elapsed since the last sample point
    assign bit_tick = (timer == LAST_TICK);
    assign sample_data = (state == RX_DATA) && bit_tick;
    // good frame, stop bit seen high at its middle
    assign stop_ok = (state == RX_STOP) && bit_tick && rxd_sync;

    ////////////////////////////////////////
    // bit timing and framing
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            state <= RX_IDLE;
            timer <= '0;
            bit_idx <= '0;
            byte_cnt <= '0;
            word_valid <= 1'b0;
        end else begin
            // two flop synchronizer, line idles high
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            word_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    timer <= '0;
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck at mid start bit, a glitch goes back to idle
                    if (timer == HALF_TICK) begin
                        timer <= '0;
                        bit_idx <= '0;
                        state <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        timer <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        timer <= '0;
                        state <= RX_IDLE;
                        if (rxd_sync) begin
                            byte_cnt <= byte_cnt + 1'b1;
                            word_valid <= (byte_cnt == 2'd3);
                        end else begin
                            // framing error, restart word assembly
                            byte_cnt <= '0;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // data path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        // lsb first on the wire
        if (sample_data) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
        // first byte lands in bits 7:0
        if (stop_ok) begin
            word_buf[{byte_cnt, 3'b000} +: 8] <= shift_reg;
        end
    end

    assign rx_word.valid = word_valid;
    assign rx_word.data = word_buf;

endmodule

//--- sim/tb_iram_top.sv
`timescale 1ns/1ps
`include "iram_cfg.svh"

module tb_iram_top;

    localparam int CLK_NS = 4;
    localparam logic [31:0] SEED = 32'h4df813e4;
    // first program, then a shorter one over it
    localparam int N1 = 12;
    localparam int N2 = 5;
    localparam int PAT_LEN = 4096;
    localparam int DRAIN_CYCLES = 4 * `IRAM_DEPTH;
    // two loads with markers plus two stray words, 40 bit times each
    localparam longint RUN_CYCLES = (N1 + N2 + 6) * 40 * `UART_CLKS_PER_BIT
                                    + DRAIN_CYCLES + 2000;

    logic clk = 1'b0;
    logic rst;
    logic rxd;
    logic instr_ready;
    logic loading;
    iram_pkg::fetch_out_s instr_out;

    ////////////////////////////////////////
    // reference model and bookkeeping
    ////////////////////////////////////////

    iram_pkg::word_t ref_mem [`IRAM_DEPTH];
    bit ref_known [`IRAM_DEPTH];
    // words of the load in progress, committed when it closes
    iram_pkg::word_t stage_mem [`IRAM_DEPTH];
    int stage_len = 0;
    iram_pkg::iram_addr_t exp_pc = '0;
    bit ready_pat [PAT_LEN];
    bit ready_random = 1'b0;
    bit loading_q = 1'b0;
    int pat_idx = 0;
    int since_restart = 0;
    int xfer_count = 0;
    int err_count = 0;

    iram_top DUT (
        .clk(clk),
        .rst(rst),
        .rxd(rxd),
        .instr_ready(instr_ready),
        .instr_out(instr_out),
        .loading(loading)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ready moves just after the edge, held high until random mode
    always @(posedge clk) begin
        #1;
        if (ready_random) begin
            instr_ready = ready_pat[pat_idx];
            pat_idx = (pat_idx + 1) % PAT_LEN;
        end else begin
            instr_ready = 1'b1;
        end
    end

    ////////////////////////////////////////
    // protocol assertions
    ////////////////////////////////////////

    a_reset: assert property (@(posedge clk) rst |=> (!loading && !instr_out.valid))
        else begin
            err_count++;
            $display("[ERROR] %0t: loading or valid high after a reset cycle", $time);
        end

    // stalled output holds, only a finished load may flush it
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (instr_out.valid && !instr_ready)
        |=> ((instr_out === $past(instr_out)) || $fell(loading)))
        else begin
            err_count++;
            $display("[ERROR] %0t: instr_out changed while stalled", $time);
        end

    // no fresh read completes once a load is under way
    a_no_fetch: assert property (@(posedge clk) disable iff (rst)
        (loading && $past(loading) && !instr_out.valid) |=> !instr_out.valid)
        else begin
            err_count++;
            $display("[ERROR] %0t: valid rose for a new pc during a load", $time);
        end

    ////////////////////////////////////////
    // transfer monitor
    ////////////////////////////////////////

    // negedge sampling, inputs and outputs are both settled here
    always @(negedge clk) begin : monitor
        int i;
        if (rst) begin
            exp_pc = '0;
            loading_q = 1'b0;
        end else begin
            // load just closed, memory now holds the staged words
            if (loading_q && !loading) begin
                for (i = 0; i < stage_len; i++) begin
                    ref_mem[i] = stage_mem[i];
                    ref_known[i] = 1'b1;
                end
                exp_pc = '0;
                since_restart = 0;
            end
            loading_q = loading;
            if (instr_out.valid && instr_ready) begin
                assert (instr_out.pc == exp_pc) else begin
                    err_count++;
                    $display("[ERROR] %0t: pc %0d delivered, expected %0d",
                             $time, instr_out.pc, exp_pc);
                end
                assert (!ref_known[exp_pc]
                        || instr_out.instr === ref_mem[exp_pc]) else begin
                    err_count++;
                    $display("[ERROR] %0t: pc %0d instr %h, expected %h", $time,
                             exp_pc, instr_out.instr, ref_mem[exp_pc]);
                end
                assert (instr_out.instr !== `IRAM_PROG_START
                        && instr_out.instr !== `IRAM_PROG_END) else begin
                    err_count++;
                    $display("[ERROR] %0t: marker %h delivered at pc %0d",
                             $time, instr_out.instr, instr_out.pc);
                end
                // next pc in order, wraps with the address width
                exp_pc = exp_pc + 1'b1;
                since_restart++;
                xfer_count++;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    function automatic iram_pkg::word_t random_word();
        iram_pkg::word_t w;
        w = $urandom();
        while (w == `IRAM_PROG_START || w == `IRAM_PROG_END) begin
            w = $urandom();
        end
        return w;
    endfunction

    // one bit on the line for a full bit time
    task automatic send_bit(input logic b);
        @(posedge clk);
        #1;
        rxd = b;
        repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // four 8N1 frames, low byte first, lsb first
    task automatic send_word(input iram_pkg::word_t w);
        iram_pkg::byte_t b;
        int k;
        int j;
        for (k = 0; k < 4; k++) begin
            b = w[8*k +: 8];
            send_bit(1'b0);
            for (j = 0; j < 8; j++) begin
                send_bit(b[j]);
            end
            send_bit(1'b1);
        end
    endtask

    task automatic wait_loading(input logic level);
        int n;
        n = 0;
        while (loading !== level && n < 64) begin
            @(negedge clk);
            n++;
        end
        assert (loading === level) else begin
            err_count++;
            $display("loading did not go to %0b within 64 cycles of the marker", level);
        end
    endtask

    task automatic wait_transfers(input int count);
        int n;
        n = 0;
        while (since_restart < count && n < DRAIN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        assert (since_restart >= count) else begin
            err_count++;
            $display("only %0d of %0d instructions came out after the load",
                     since_restart, count);
        end
    endtask

    task automatic load_program(input int n);
        int i;
        send_word(`IRAM_PROG_START);
        wait_loading(1'b1);
        stage_len = n;
        for (i = 0; i < n; i++) begin
            stage_mem[i] = random_word();
            send_word(stage_mem[i]);
        end
        send_word(`IRAM_PROG_END);
        wait_loading(1'b0);
        // monitor commits on the falling edge first
        @(negedge clk);
    endtask

    // word outside a load, must be ignored
    task automatic send_stray(input iram_pkg::word_t w);
        send_word(w);
        repeat (4 * `UART_CLKS_PER_BIT) begin
            @(negedge clk);
            assert (!loading) else begin
                err_count++;
                $display("[ERROR] %0t: loading rose on stray word %h", $time, w);
            end
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] seed_sink;
        int idx;
        int len;
        int k;
        bit lvl;
        rst = 1'b1;
        rxd = 1'b1;
        instr_ready = 1'b0;
        seed_sink = $urandom(SEED);
        // ready stretches of one to six cycles
        idx = 0;
        while (idx < PAT_LEN) begin
            lvl = $urandom_range(1, 0);
            len = $urandom_range(6, 1);
            for (k = 0; k < len && idx < PAT_LEN; k++) begin
                ready_pat[idx] = lvl;
                idx++;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!loading && !instr_out.valid) else begin
            err_count++;
            $display("[ERROR] %0t: loading or valid high after reset", $time);
        end
        load_program(N1);
        wait_transfers(N1 + 4);
        // back pressure from here on
        ready_random = 1'b1;
        load_program(N2);
        wait_transfers(N1 + 2);
        send_stray(random_word());
        send_stray(`IRAM_PROG_END);
        // one full pass brings pc 0 to N1-1 round again
        wait_transfers(`IRAM_DEPTH + N1 + 2);
        $display("summary: %0d transfers checked, %0d errors", xfer_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        err_count++;
        $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
        $display("summary: %0d transfers checked, %0d errors", xfer_count, err_count);
        $display("Checks failed");
        $finish;
    end

endmodule
